/* filelist.f */
+incdir+hw
hw/mcuPkg.sv
hw/opDecoder.sv
hw/aluControlDecoder.sv
hw/cycleSequencer.sv
hw/controlEncoder.sv
hw/multiCycleControl.sv
sim/tbMultiCycleControl.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tbMultiCycleControl
RTL_TOP  = multiCycleControl
FILELIST = filelist.f
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "\*\* FAIL \*\*" $(LOG); then exit 1; fi
	@grep -q "\*\* PASS \*\*" $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

/* sim/tbMultiCycleControl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mcu_macros.svh"

module tbMultiCycleControl;

    localparam int NumProg = 21;
    localparam int NumInstr = 60;

    logic clk;
    logic rstn;
    logic [`OP_W-1:0] op;
    logic [`FUNCT_W-1:0] funct;
    logic uBusy;
    logic rxReady;
    logic iOrD, memWrite, irWrite, pcWrite, branch, toggleEqual;
    logic aluSrcA, regWrite, bOrL, outLatch, txStart;
    mcuPkg::pcSrcE pcSrc;
    mcuPkg::srcBE aluSrcB;
    mcuPkg::regDstE regDst;
    mcuPkg::memToRegE memToReg;
    mcuPkg::aluCtrlE aluControl;
    mcuPkg::seqStateE state;

    mcuPkg::seqStateE expState;
    logic [`OP_W-1:0] progOp [0:NumProg-1];
    logic [`FUNCT_W-1:0] progFn [0:NumProg-1];
    integer seed = 32'he5d16173;
    int waitLeft = 0;
    int instrWait = 0;
    int totalWait = 0;
    int cycles = 0;
    int instrCycles = 0;
    bit started = 0;

    multiCycleControl UUT (
        .clk(clk), .rstn(rstn), .op(op), .funct(funct), .uBusy(uBusy), .rxReady(rxReady),
        .iOrD(iOrD), .memWrite(memWrite), .irWrite(irWrite), .pcWrite(pcWrite),
        .branch(branch), .toggleEqual(toggleEqual), .aluSrcA(aluSrcA), .regWrite(regWrite),
        .bOrL(bOrL), .outLatch(outLatch), .txStart(txStart), .pcSrc(pcSrc),
        .aluSrcB(aluSrcB), .regDst(regDst), .memToReg(memToReg),
        .aluControl(aluControl), .state(state)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic checkField(input string name, input int expVal, input int actVal);
        assert (expVal == actVal)
            else failRun($sformatf("ERR t=%0t %s expected %0h actual %0h",
                                   $time, name, expVal, actVal));
    endtask

    function automatic mcuPkg::opClassE classify(input logic [5:0] o, input logic [5:0] f);
        case (o)
            `OPC_RTYPE: return (f == `FN_JR) ? mcuPkg::opJr : mcuPkg::opRType;
            `OPC_LW:    return mcuPkg::opLoad;
            `OPC_SW:    return mcuPkg::opStore;
            `OPC_ADDI:  return mcuPkg::opAddi;
            `OPC_ANDI:  return mcuPkg::opAndi;
            `OPC_ORI:   return mcuPkg::opOri;
            `OPC_SLTI:  return mcuPkg::opSlti;
            `OPC_LUI:   return mcuPkg::opLui;
            `OPC_BEQ:   return mcuPkg::opBeq;
            `OPC_BNE:   return mcuPkg::opBne;
            `OPC_J:     return mcuPkg::opJump;
            `OPC_JAL:   return mcuPkg::opJal;
            `OPC_OUT:   return mcuPkg::opOut;
            `OPC_IN:    return mcuPkg::opIn;
            default:    return mcuPkg::opIllegal;
        endcase
    endfunction

    // fetch to fetch length without serial waits
    function automatic int cyclesFor(input mcuPkg::opClassE c);
        case (c)
            mcuPkg::opLoad: return 7;
            mcuPkg::opOut: return 6;
            mcuPkg::opBeq, mcuPkg::opBne, mcuPkg::opJump, mcuPkg::opJal: return 4;
            mcuPkg::opIllegal: return 3;
            default: return 5;
        endcase
    endfunction

    // expected state in cycle n of an instruction counted from sFetch
    function automatic mcuPkg::seqStateE pathState(input mcuPkg::opClassE c, input int n,
                                                   input int w);
        int len;
        len = cyclesFor(c) + ((c inside {mcuPkg::opOut, mcuPkg::opIn}) ? w : 0);
        if (n == 1 || n > len) return mcuPkg::sFetch;
        if (n == 2) return mcuPkg::sFetchWait;
        if (n == 3) return mcuPkg::sDecode;
        case (c)
            mcuPkg::opRType, mcuPkg::opJr:
                return (n == 4) ? mcuPkg::sExecute : mcuPkg::sAluWriteback;
            mcuPkg::opLoad: begin
                case (n)
                    4: return mcuPkg::sMemAdr;
                    5: return mcuPkg::sMemRead;
                    6: return mcuPkg::sMemReadWait;
                    default: return mcuPkg::sMemWriteback;
                endcase
            end
            mcuPkg::opStore: return (n == 4) ? mcuPkg::sMemAdr : mcuPkg::sMemWrite;
            mcuPkg::opLui:   return (n == 4) ? mcuPkg::sLoadUi : mcuPkg::sLuiWriteback;
            mcuPkg::opBeq:   return mcuPkg::sBranch;
            mcuPkg::opBne:   return mcuPkg::sBranchNe;
            mcuPkg::opJump:  return mcuPkg::sJump;
            mcuPkg::opJal:   return mcuPkg::sJumpLink;
            mcuPkg::opOut: begin
                if (n == 4) return mcuPkg::sOutPre;
                if (n == 5) return mcuPkg::sOutWait;
                return mcuPkg::sOutDone; // held while the transmitter is busy
            end
            mcuPkg::opIn:    return (n == len) ? mcuPkg::sInWrite : mcuPkg::sInWait;
            default:         return (n == 4) ? mcuPkg::sImmExecute : mcuPkg::sImmWriteback;
        endcase
    endfunction

    // alu codes and 000, or 001, add 010, sub 110, slt 111
    function automatic int aluCodeFor(input mcuPkg::seqStateE s, input mcuPkg::opClassE c,
                                      input logic [5:0] f);
        if (s == mcuPkg::sBranch || s == mcuPkg::sBranchNe) return 3'b110;
        if (s == mcuPkg::sImmExecute) begin
            if (c == mcuPkg::opAndi) return 3'b000;
            if (c == mcuPkg::opOri) return 3'b001;
            if (c == mcuPkg::opSlti) return 3'b111;
            return 3'b010;
        end
        if (s != mcuPkg::sExecute) return 3'b010;
        case (f)
            `FN_ADD, `FN_JR: return 3'b010;
            `FN_SUB: return 3'b110;
            `FN_OR:  return 3'b001;
            `FN_SLT: return 3'b111;
            default: return 3'b000;
        endcase
    endfunction

    task automatic checkControls(input mcuPkg::seqStateE s, input mcuPkg::opClassE c);
        bit isJump;
        bit isLink;
        bit isBr;
        isJump = (s == mcuPkg::sJump || s == mcuPkg::sJumpLink);
        isLink = (s == mcuPkg::sJumpLink);
        isBr = (s == mcuPkg::sBranch || s == mcuPkg::sBranchNe);
        checkField("iOrD", s inside {mcuPkg::sMemRead, mcuPkg::sMemReadWait,
                                     mcuPkg::sMemWrite}, iOrD);
        checkField("memWrite", s == mcuPkg::sMemWrite, memWrite);
        checkField("irWrite", s == mcuPkg::sFetch, irWrite);
        checkField("pcWrite", s == mcuPkg::sFetch || isJump ||
                   (s == mcuPkg::sExecute && c == mcuPkg::opJr), pcWrite);
        checkField("branch", isBr, branch);
        checkField("toggleEqual", s == mcuPkg::sBranchNe, toggleEqual);
        checkField("aluSrcA", isBr || s inside {mcuPkg::sMemAdr, mcuPkg::sExecute,
                   mcuPkg::sImmExecute, mcuPkg::sLoadUi}, aluSrcA);
        checkField("regWrite", isLink || s inside {mcuPkg::sMemWriteback,
                   mcuPkg::sAluWriteback, mcuPkg::sImmWriteback, mcuPkg::sLuiWriteback,
                   mcuPkg::sInWrite}, regWrite);
        checkField("bOrL", s == mcuPkg::sLoadUi, bOrL);
        checkField("outLatch", s == mcuPkg::sOutPre, outLatch);
        checkField("txStart", s == mcuPkg::sOutWait, txStart);
        checkField("pcSrc", isJump ? 2 : (isBr ? 1 : 0), pcSrc);
        checkField("aluSrcB", s == mcuPkg::sFetch ? 1 : (s == mcuPkg::sDecode ? 3 :
                   (s inside {mcuPkg::sMemAdr, mcuPkg::sImmExecute, mcuPkg::sLoadUi} ? 2 : 0)),
                   aluSrcB);
        checkField("regDst", isLink ? 2 : (s == mcuPkg::sAluWriteback ? 1 : 0), regDst);
        checkField("memToReg", s == mcuPkg::sMemWriteback ? 1 : (isLink ? 2 :
                   (s == mcuPkg::sInWrite ? 3 : 0)), memToReg);
        checkField("aluControl", aluCodeFor(s, c, funct), aluControl);
    endtask

    // transmitter busy time and receiver delay
    always @(posedge clk) begin
        if (!rstn) begin
            uBusy <= 1'b0;
            rxReady <= 1'b0;
        end else begin
            case (state)
                mcuPkg::sDecode: begin
                    if (classify(op, funct) inside {mcuPkg::opOut, mcuPkg::opIn}) begin
                        waitLeft = $unsigned($random(seed)) % 6;
                        instrWait = waitLeft;
                        totalWait += waitLeft;
                    end
                    rxReady <= (classify(op, funct) == mcuPkg::opIn) && (waitLeft == 0);
                end
                mcuPkg::sOutWait: uBusy <= (waitLeft != 0);
                mcuPkg::sOutDone: begin
                    if (waitLeft > 0) waitLeft--;
                    uBusy <= (waitLeft != 0);
                end
                mcuPkg::sInWait: begin
                    if (!rxReady) begin
                        waitLeft--;
                        rxReady <= (waitLeft == 0);
                    end else begin
                        rxReady <= 1'b0; // byte taken
                    end
                end
                default: begin
                    uBusy <= 1'b0;
                    rxReady <= 1'b0;
                end
            endcase
        end
    end

    // outputs are stable mid-cycle
    always @(negedge clk) begin
        if (rstn) begin
            instrCycles++;
            expState = started ? pathState(classify(op, funct), instrCycles, instrWait)
                               : mcuPkg::sFetch;
            checkField("state", expState, state);
            checkControls(state, classify(op, funct));
            if (state == mcuPkg::sFetch) begin
                started = 1;
                instrCycles = 1;
            end
            cycles++;
            if (cycles > NumInstr * 12 + totalWait)
                failRun("timeout: sequencer stopped returning to Fetch");
        end
    end

    initial begin
        int idx;
        progOp = '{`OPC_LW, `OPC_SW, `OPC_RTYPE, `OPC_RTYPE, `OPC_RTYPE, `OPC_RTYPE,
                   `OPC_RTYPE, `OPC_RTYPE, `OPC_ADDI, `OPC_ANDI, `OPC_ORI, `OPC_SLTI,
                   `OPC_LUI, `OPC_BEQ, `OPC_BNE, `OPC_J, `OPC_JAL, `OPC_OUT, `OPC_IN,
                   6'b111111, `OPC_RTYPE};
        progFn = '{6'd0, 6'd0, `FN_ADD, `FN_SUB, `FN_AND, `FN_OR, `FN_SLT, `FN_JR,
                   6'd0, 6'd0, 6'd0, 6'd0, 6'd0, 6'd0, 6'd0, 6'd0, 6'd0, 6'd0, 6'd0,
                   6'd0, 6'b111111};
        rstn = 1'b0;
        op = `OPC_RTYPE;
        funct = `FN_ADD;
        uBusy = 1'b0;
        rxReady = 1'b0;
        repeat (8) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        checkField("state", mcuPkg::sFetch, state); // right after reset
        checkField("regWrite", 0, regWrite);
        checkField("memWrite", 0, memWrite);
        checkField("txStart", 0, txStart);
        checkField("branch", 0, branch);
        checkField("toggleEqual", 0, toggleEqual);
        for (int i = 0; i < NumInstr; i++) begin
            @(posedge clk);
            while (state != mcuPkg::sFetch) @(posedge clk);
            idx = (i < NumProg) ? i : $unsigned($random(seed)) % NumProg;
            op <= progOp[idx];
            funct <= progFn[idx];
        end
        @(posedge clk);
        while (state != mcuPkg::sFetch) @(posedge clk);
        @(negedge clk);
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

/* hw/multiCycleControl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mcu_macros.svh"

module multiCycleControl (
    input  wire                     clk,
    input  wire                     rstn,
    input  wire [`OP_W-1:0]         op,
    input  wire [`FUNCT_W-1:0]      funct,
    input  wire                     uBusy,   // transmitter shifting
    input  wire                     rxReady, // receiver holds a byte
    output wire                     iOrD,
    output wire                     memWrite,
    output wire                     irWrite,
    output wire                     pcWrite,
    output wire                     branch,
    output wire                     toggleEqual,
    output wire                     aluSrcA,
    output wire                     regWrite,
    output wire                     bOrL,
    output wire                     outLatch,
    output wire                     txStart,
    output wire mcuPkg::pcSrcE      pcSrc,
    output wire mcuPkg::srcBE       aluSrcB,
    output wire mcuPkg::regDstE     regDst,
    output wire mcuPkg::memToRegE   memToReg,
    output wire mcuPkg::aluCtrlE    aluControl,
    output wire mcuPkg::seqStateE   state
);

    wire mcuPkg::opClassE opClass;

    opDecoder opDec (
        .op      (op),
        .funct   (funct),
        .opClass (opClass)
    );

    cycleSequencer seq (
        .clk     (clk),
        .rstn    (rstn),
        .opClass (opClass),
        .uBusy   (uBusy),
        .rxReady (rxReady),
        .state   (state)
    );

    controlEncoder ctrlEnc (
        .state       (state),
        .opClass     (opClass),
        .funct       (funct),
        .iOrD        (iOrD),
        .memWrite    (memWrite),
        .irWrite     (irWrite),
        .pcWrite     (pcWrite),
        .branch      (branch),
        .toggleEqual (toggleEqual),
        .aluSrcA     (aluSrcA),
        .regWrite    (regWrite),
        .bOrL        (bOrL),
        .outLatch    (outLatch),
        .txStart     (txStart),
        .pcSrc       (pcSrc),
        .aluSrcB     (aluSrcB),
        .regDst      (regDst),
        .memToReg    (memToReg),
        .aluControl  (aluControl)
    );

endmodule

`default_nettype wire

/* hw/controlEncoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mcu_macros.svh"

module controlEncoder (
    input  wire mcuPkg::seqStateE state,
    input  wire mcuPkg::opClassE  opClass,
    input  wire [`FUNCT_W-1:0]    funct,
    output logic                  iOrD,
    output logic                  memWrite,
    output logic                  irWrite,
    output logic                  pcWrite,
    output logic                  branch,
    output logic                  toggleEqual,
    output logic                  aluSrcA,
    output logic                  regWrite,
    output logic                  bOrL,
    output logic                  outLatch,
    output logic                  txStart,
    output mcuPkg::pcSrcE         pcSrc,
    output mcuPkg::srcBE          aluSrcB,
    output mcuPkg::regDstE        regDst,
    output mcuPkg::memToRegE      memToReg,
    output mcuPkg::aluCtrlE       aluControl
);

    mcuPkg::aluOpE aluOp;

    always_comb begin
        iOrD        = 1'b0;
        memWrite    = 1'b0;
        irWrite     = 1'b0;
        pcWrite     = 1'b0;
        branch      = 1'b0;
        toggleEqual = 1'b0;
        aluSrcA     = 1'b0;
        regWrite    = 1'b0;
        bOrL        = 1'b0;
        outLatch    = 1'b0;
        txStart     = 1'b0;
        pcSrc       = mcuPkg::pcFromAlu;
        aluSrcB     = mcuPkg::srcReg;
        regDst      = mcuPkg::dstRt;
        memToReg    = mcuPkg::wbAluOut;
        aluOp       = mcuPkg::aluAdd;
        case (state)
            mcuPkg::sFetch: begin
                irWrite = 1'b1;
                pcWrite = 1'b1; // pc + 4
                aluSrcB = mcuPkg::srcFour;
            end
            mcuPkg::sDecode: aluSrcB = mcuPkg::srcImmShifted; // branch target ahead of time
            mcuPkg::sMemAdr: begin
                aluSrcA = 1'b1;
                aluSrcB = mcuPkg::srcImm;
            end
            mcuPkg::sMemRead,
            mcuPkg::sMemReadWait: iOrD = 1'b1;
            mcuPkg::sMemWriteback: begin
                regWrite = 1'b1;
                memToReg = mcuPkg::wbMem;
            end
            mcuPkg::sMemWrite: begin
                iOrD     = 1'b1;
                memWrite = 1'b1;
            end
            mcuPkg::sExecute: begin
                aluSrcA = 1'b1;
                aluOp   = mcuPkg::aluFunct;
                pcWrite = (opClass == mcuPkg::opJr); // jr loads rs into pc
            end
            mcuPkg::sAluWriteback: begin
                regWrite = 1'b1;
                regDst   = mcuPkg::dstRd;
            end
            mcuPkg::sImmExecute: begin
                aluSrcA = 1'b1;
                aluSrcB = mcuPkg::srcImm;
                case (opClass)
                    mcuPkg::opAndi: aluOp = mcuPkg::aluAnd;
                    mcuPkg::opOri:  aluOp = mcuPkg::aluOr;
                    mcuPkg::opSlti: aluOp = mcuPkg::aluSlt;
                    default:        aluOp = mcuPkg::aluAdd; // addi
                endcase
            end
            mcuPkg::sImmWriteback,
            mcuPkg::sLuiWriteback: regWrite = 1'b1;
            mcuPkg::sLoadUi: begin
                aluSrcA = 1'b1;
                aluSrcB = mcuPkg::srcImm;
                bOrL    = 1'b1; // immediate to upper half
            end
            mcuPkg::sBranch,
            mcuPkg::sBranchNe: begin
                aluSrcA     = 1'b1;
                aluOp       = mcuPkg::aluSub;
                branch      = 1'b1;
                pcSrc       = mcuPkg::pcFromAluOut;
                toggleEqual = (state == mcuPkg::sBranchNe); // invert zero flag for bne
            end
            mcuPkg::sJump,
            mcuPkg::sJumpLink: begin
                pcWrite = 1'b1;
                pcSrc   = mcuPkg::pcFromJump;
                if (state == mcuPkg::sJumpLink) begin
                    regWrite = 1'b1;
                    regDst   = mcuPkg::dstRa;
                    memToReg = mcuPkg::wbPcLink;
                end
            end
            mcuPkg::sOutPre:  outLatch = 1'b1;
            mcuPkg::sOutWait: txStart  = 1'b1; // single-cycle start pulse
            mcuPkg::sInWrite: begin
                regWrite = 1'b1;
                memToReg = mcuPkg::wbRx;
            end
            default: ;
        endcase
    end

    aluControlDecoder aluDec (
        .aluOp      (aluOp),
        .funct      (funct),
        .aluControl (aluControl)
    );

endmodule

`default_nettype wire

/* hw/cycleSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module cycleSequencer (
    input  wire                 clk,
    input  wire                 rstn,
    input  wire mcuPkg::opClassE opClass,
    input  wire                 uBusy,
    input  wire                 rxReady,
    output mcuPkg::seqStateE    state
);

    mcuPkg::seqStateE nextState;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= mcuPkg::sFetch;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = mcuPkg::sFetch; // terminal states fall back here
        case (state)
            mcuPkg::sFetch:     nextState = mcuPkg::sFetchWait;
            mcuPkg::sFetchWait: nextState = mcuPkg::sDecode;
            mcuPkg::sDecode: begin
                case (opClass)
                    mcuPkg::opRType,
                    mcuPkg::opJr:    nextState = mcuPkg::sExecute;
                    mcuPkg::opLoad,
                    mcuPkg::opStore: nextState = mcuPkg::sMemAdr;
                    mcuPkg::opAddi,
                    mcuPkg::opAndi,
                    mcuPkg::opOri,
                    mcuPkg::opSlti:  nextState = mcuPkg::sImmExecute;
                    mcuPkg::opLui:   nextState = mcuPkg::sLoadUi;
                    mcuPkg::opBeq:   nextState = mcuPkg::sBranch;
                    mcuPkg::opBne:   nextState = mcuPkg::sBranchNe;
                    mcuPkg::opJump:  nextState = mcuPkg::sJump;
                    mcuPkg::opJal:   nextState = mcuPkg::sJumpLink;
                    mcuPkg::opOut:   nextState = mcuPkg::sOutPre;
                    mcuPkg::opIn:    nextState = mcuPkg::sInWait;
                    default:         nextState = mcuPkg::sFetch; // illegal opcode
                endcase
            end
            mcuPkg::sMemAdr: begin
                if (opClass == mcuPkg::opLoad) begin
                    nextState = mcuPkg::sMemRead;
                end else begin
                    nextState = mcuPkg::sMemWrite;
                end
            end
            mcuPkg::sMemRead:     nextState = mcuPkg::sMemReadWait;
            mcuPkg::sMemReadWait: nextState = mcuPkg::sMemWriteback; // memory latency
            mcuPkg::sExecute:     nextState = mcuPkg::sAluWriteback;
            mcuPkg::sImmExecute:  nextState = mcuPkg::sImmWriteback;
            mcuPkg::sLoadUi:      nextState = mcuPkg::sLuiWriteback;
            mcuPkg::sOutPre:      nextState = mcuPkg::sOutWait;
            mcuPkg::sOutWait:     nextState = mcuPkg::sOutDone;
            mcuPkg::sOutDone: begin
                // transmitter still shifting the byte out
                if (uBusy) begin
                    nextState = mcuPkg::sOutDone;
                end else begin
                    nextState = mcuPkg::sFetch;
                end
            end
            mcuPkg::sInWait: begin
                if (rxReady) begin
                    nextState = mcuPkg::sInWrite;
                end else begin
                    nextState = mcuPkg::sInWait; // no byte yet
                end
            end
            default: nextState = mcuPkg::sFetch;
        endcase
    end

endmodule

`default_nettype wire

/* hw/aluControlDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mcu_macros.svh"

module aluControlDecoder (
    input  wire mcuPkg::aluOpE  aluOp,
    input  wire [`FUNCT_W-1:0]  funct,
    output mcuPkg::aluCtrlE     aluControl
);

    always_comb begin
        case (aluOp)
            mcuPkg::aluAdd: aluControl = mcuPkg::ctrlAdd;
            mcuPkg::aluSub: aluControl = mcuPkg::ctrlSub;
            mcuPkg::aluAnd: aluControl = mcuPkg::ctrlAnd;
            mcuPkg::aluOr:  aluControl = mcuPkg::ctrlOr;
            mcuPkg::aluSlt: aluControl = mcuPkg::ctrlSlt;
            mcuPkg::aluFunct: begin
                // R-type operation lives in the function field
                case (funct)
                    `FN_ADD: aluControl = mcuPkg::ctrlAdd;
                    `FN_SUB: aluControl = mcuPkg::ctrlSub;
                    `FN_AND: aluControl = mcuPkg::ctrlAnd;
                    `FN_OR:  aluControl = mcuPkg::ctrlOr;
                    `FN_SLT: aluControl = mcuPkg::ctrlSlt;
                    `FN_JR:  aluControl = mcuPkg::ctrlAdd; // harmless add for jr
                    default: aluControl = mcuPkg::ctrlAnd; // all-zero code
                endcase
            end
            default: aluControl = mcuPkg::ctrlAnd;
        endcase
    end

endmodule

`default_nettype wire

/* hw/opDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mcu_macros.svh"

module opDecoder (
    input  wire [`OP_W-1:0]    op,
    input  wire [`FUNCT_W-1:0] funct,
    output mcuPkg::opClassE    opClass
);

    always_comb begin
        case (op)
            `OPC_RTYPE: begin
                // jr shares the R-type opcode
                if (funct == `FN_JR) begin
                    opClass = mcuPkg::opJr;
                end else begin
                    opClass = mcuPkg::opRType;
                end
            end
            `OPC_LW:   opClass = mcuPkg::opLoad;
            `OPC_SW:   opClass = mcuPkg::opStore;
            `OPC_ADDI: opClass = mcuPkg::opAddi;
            `OPC_ANDI: opClass = mcuPkg::opAndi;
            `OPC_ORI:  opClass = mcuPkg::opOri;
            `OPC_SLTI: opClass = mcuPkg::opSlti;
            `OPC_LUI:  opClass = mcuPkg::opLui;
            `OPC_BEQ:  opClass = mcuPkg::opBeq;
            `OPC_BNE:  opClass = mcuPkg::opBne;
            `OPC_J:    opClass = mcuPkg::opJump;
            `OPC_JAL:  opClass = mcuPkg::opJal;
            `OPC_OUT:  opClass = mcuPkg::opOut; // serial transmit
            `OPC_IN:   opClass = mcuPkg::opIn;  // serial receive
            default:   opClass = mcuPkg::opIllegal; // treated as no-op
        endcase
    end

endmodule

`default_nettype wire

/* hw/mcuPkg.sv */
`default_nettype none

package mcuPkg;

    // decoded instruction class
    typedef enum logic [3:0] {
        opRType, opJr, opLoad, opStore,
        opAddi, opAndi, opOri, opSlti,
        opLui, opBeq, opBne, opJump,
        opJal, opOut, opIn, opIllegal
    } opClassE;

    // one state per instruction phase
    typedef enum logic [4:0] {
        sFetch, sFetchWait, sDecode,
        sMemAdr, sMemRead, sMemReadWait, sMemWriteback, sMemWrite,
        sExecute, sAluWriteback,
        sImmExecute, sImmWriteback,
        sLoadUi, sLuiWriteback,
        sBranch, sBranchNe,
        sJump, sJumpLink,
        sOutPre, sOutWait, sOutDone,
        sInWait, sInWrite
    } seqStateE;

    typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt, aluFunct} aluOpE;

    // codes seen by the ALU
    typedef enum logic [2:0] {
        ctrlAnd = 3'b000,
        ctrlOr  = 3'b001,
        ctrlAdd = 3'b010,
        ctrlSub = 3'b110,
        ctrlSlt = 3'b111
    } aluCtrlE;

    typedef enum logic [1:0] {pcFromAlu, pcFromAluOut, pcFromJump} pcSrcE;
    typedef enum logic [1:0] {srcReg, srcFour, srcImm, srcImmShifted} srcBE;
    typedef enum logic [1:0] {dstRt, dstRd, dstRa} regDstE;
    typedef enum logic [1:0] {wbAluOut, wbMem, wbPcLink, wbRx} memToRegE;

endpackage

`default_nettype wire

/* hw/mcu_macros.svh */
`ifndef MCU_MACROS_SVH
`define MCU_MACROS_SVH

// instruction register field widths
`define OP_W    6
`define FUNCT_W 6

// primary opcodes
`define OPC_RTYPE 6'b000000
`define OPC_LW    6'b100011
`define OPC_SW    6'b101011
`define OPC_ADDI  6'b001000
`define OPC_ANDI  6'b001100
`define OPC_ORI   6'b001101
`define OPC_SLTI  6'b001010
`define OPC_LUI   6'b001111

// control transfer
`define OPC_BEQ   6'b000100
`define OPC_BNE   6'b000101
`define OPC_J     6'b000010
`define OPC_JAL   6'b000011

// serial port access
`define OPC_OUT   6'b011011
`define OPC_IN    6'b011010

// R-type function codes
`define FN_ADD    6'b100000
`define FN_SUB    6'b100010
`define FN_AND    6'b100100
`define FN_OR     6'b100101
`define FN_SLT    6'b101010
`define FN_JR     6'b001000 // R-type encoded jump through rs

`endif
